//--- hdl/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// pc after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// 256 words of 8 bytes
`define IMEM_DEPTH_LOG2 8

// word zero sits at the reset pc
`define IMEM_BASE `FETCH_RESET_PC

// wait between ar accept and r_valid
`define IMEM_LATENCY 3

// addi x0,x0,0
`define NOP_INST 32'h0000_0013

`endif

//--- hdl/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // byte address in instruction space
  typedef logic [63:0] addr_t;

  // one data beat on the read data channel
  typedef logic [63:0] word_t;

  // single rv instruction
  typedef logic [31:0] inst_t;

  // axi response code
  typedef logic [1:0] resp_t;

  // response encodings used on r_resp
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // fetch master states
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } fetch_state_e;

endpackage

`default_nettype wire

//--- hdl/axi_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_rd_if;
  import fetch_pkg::*;

  // read address channel
  logic  ar_valid;
  logic  ar_ready;
  addr_t ar_addr;

  // read data channel, single beat only
  logic  r_valid;
  logic  r_ready;
  word_t r_data;
  resp_t r_resp;
  logic  r_last;

  // fetch side
  modport master (
    output ar_valid, ar_addr, r_ready,
    input  ar_ready, r_valid, r_data, r_resp, r_last
  );

  // memory side
  modport slave (
    input  ar_valid, ar_addr, r_ready,
    output ar_ready, r_valid, r_data, r_resp, r_last
  );

endinterface

`default_nettype wire

//--- hdl/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module pc_gen (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  input  wire              stall_i,
  input  wire              done_i,
  output fetch_pkg::addr_t pc_o,
  output logic             pc_ok_o
);
  import fetch_pkg::*;

  // current fetch address
  addr_t pc_q;

  // next sequential address
  addr_t pc_inc;

  assign pc_inc = pc_q + addr_t'(64'd4);

  // redirect wins over a completing fetch
  // stall does not block the step, an in-flight fetch still retires
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (redirect_i) begin
      pc_q <= redirect_pc_i;
    end else if (done_i) begin
      pc_q <= pc_inc;
    end
  end

  assign pc_o = pc_q;

  // master may pick up pc only with no stall and no redirect
  // a redirect this cycle means pc_q is about to change
  assign pc_ok_o = !stall_i && !redirect_i;

endmodule

`default_nettype wire

//--- hdl/axi_rd_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_rd_master (
  input  wire              clk,
  input  wire              rst_n,
  input  fetch_pkg::addr_t pc_i,
  input  wire              pc_ok_i,
  input  wire              flush_i,
  axi_rd_if.master         bus,
  output logic             done_o,
  output fetch_pkg::addr_t done_pc_o,
  output fetch_pkg::word_t done_data_o,
  output logic             done_err_o
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // transaction was overtaken by a redirect
  logic  stale_q;
  // pc of the read in flight
  addr_t req_pc_q;

  logic  ar_fire;
  logic  r_fire;
  logic  issue;

  assign ar_fire = bus.ar_valid && bus.ar_ready;
  assign r_fire  = bus.r_valid && bus.r_ready;

  // hold off one cycle after done, pc_gen steps pc on that edge
  assign issue = (state_q == IDLE) && pc_ok_i && !done_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (issue) begin
          state_d = ADDR;
        end
      end
      ADDR: begin
        // ar stays up until taken, even when stale
        if (ar_fire) begin
          state_d = DATA;
        end
      end
      DATA: begin
        if (r_fire && bus.r_last) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      stale_q <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      // drop the beat if flushed before or during the transfer
      done_o  <= r_fire && !stale_q && !flush_i;
      if (r_fire) begin
        stale_q <= 1'b0;
      end else if (flush_i && (state_q != IDLE)) begin
        stale_q <= 1'b1;
      end
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if (issue) begin
      req_pc_q <= pc_i;
    end
    if (r_fire) begin
      done_pc_o   <= req_pc_q;
      done_data_o <= bus.r_data;
      done_err_o  <= (bus.r_resp != RESP_OKAY);
    end
  end

  assign bus.ar_valid = (state_q == ADDR);
  assign bus.ar_addr  = req_pc_q;
  assign bus.r_ready  = (state_q == DATA);

endmodule

`default_nettype wire

//--- hdl/imem_axi_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module imem_axi_slave (
  input  wire              clk,
  input  wire              rst_n,
  axi_rd_if.slave          bus,
  input  wire              load_we_i,
  input  fetch_pkg::addr_t load_addr_i,
  input  fetch_pkg::word_t load_data_i
);
  import fetch_pkg::*;

  localparam int DEPTH_LOG2 = `IMEM_DEPTH_LOG2;
  localparam int DEPTH      = 1 << DEPTH_LOG2;
  localparam int LAT_W      = $clog2(`IMEM_LATENCY + 1);

  // instruction storage
  word_t mem [0:DEPTH-1];

  // one outstanding read
  logic             busy_q;
  logic [LAT_W-1:0] cnt_q;
  logic             r_valid_q;
  addr_t            rd_addr_q;
  word_t            r_data_q;
  resp_t            r_resp_q;

  logic ar_fire;
  logic r_fire;

  // read side decode, offset from base
  addr_t                 rd_off;
  logic                  rd_in_range;
  logic [DEPTH_LOG2-1:0] rd_idx;

  // load side decode
  addr_t                 ld_off;
  logic                  ld_in_range;
  logic [DEPTH_LOG2-1:0] ld_idx;

  assign ar_fire = bus.ar_valid && bus.ar_ready;
  assign r_fire  = r_valid_q && bus.r_ready;

  // bits below 3 select a byte within the word
  assign rd_off      = rd_addr_q - addr_t'(`IMEM_BASE);
  assign rd_in_range = (rd_off >> (DEPTH_LOG2 + 3)) == '0;
  assign rd_idx      = rd_off[DEPTH_LOG2+2:3];

  assign ld_off      = load_addr_i - addr_t'(`IMEM_BASE);
  assign ld_in_range = (ld_off >> (DEPTH_LOG2 + 3)) == '0;
  assign ld_idx      = ld_off[DEPTH_LOG2+2:3];

  // preload port, out of window writes ignored
  always_ff @(posedge clk) begin
    if (load_we_i && ld_in_range) begin
      mem[ld_idx] <= load_data_i;
    end
  end

  // accept, count down, present, wait for r_ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      r_valid_q <= 1'b0;
    end else begin
      if (ar_fire) begin
        busy_q <= 1'b1;
        cnt_q  <= LAT_W'(`IMEM_LATENCY);
      end else if (busy_q && (cnt_q != '0)) begin
        cnt_q <= cnt_q - LAT_W'(1);
        // last wait cycle, data goes out next
        if (cnt_q == LAT_W'(1)) begin
          r_valid_q <= 1'b1;
        end
      end
      if (r_fire) begin
        r_valid_q <= 1'b0;
        busy_q    <= 1'b0;
      end
    end
  end

  // address and read data payload
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rd_addr_q <= bus.ar_addr;
    end
    if (busy_q && (cnt_q == LAT_W'(1))) begin
      // outside the window gives slverr and zero data
      r_data_q <= rd_in_range ? mem[rd_idx] : '0;
      r_resp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign bus.ar_ready = !busy_q;
  assign bus.r_valid  = r_valid_q;
  assign bus.r_data   = r_data_q;
  assign bus.r_resp   = r_resp_q;
  // single beat, always last
  assign bus.r_last   = 1'b1;

endmodule

`default_nettype wire

//--- hdl/inst_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module inst_align (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              done_i,
  input  fetch_pkg::addr_t done_pc_i,
  input  fetch_pkg::word_t done_data_i,
  input  wire              done_err_i,
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::addr_t pc_o,
  output logic             inst_valid_o,
  output logic             fetch_fault_o
);
  import fetch_pkg::*;

  // half of the word picked by pc[2]
  inst_t half_sel;
  // nop replaces a faulted fetch
  inst_t inst_d;

  assign half_sel = done_pc_i[2] ? done_data_i[63:32] : done_data_i[31:0];
  assign inst_d   = done_err_i ? inst_t'(`NOP_INST) : half_sel;

  // valid and fault are one-cycle pulses
  // inst holds until the next pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_o        <= `NOP_INST;
      inst_valid_o  <= 1'b0;
      fetch_fault_o <= 1'b0;
    end else begin
      inst_valid_o  <= done_i;
      fetch_fault_o <= done_i && done_err_i;
      if (done_i) begin
        inst_o <= inst_d;
      end
    end
  end

  // pc of the presented instruction
  always_ff @(posedge clk) begin
    if (done_i) begin
      pc_o <= done_pc_i;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  wire              clk,
  input  wire              rst_n,
  // decode side control
  input  wire              redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  input  wire              stall_i,
  // memory preload
  input  wire              load_we_i,
  input  fetch_pkg::addr_t load_addr_i,
  input  fetch_pkg::word_t load_data_i,
  // fetched instruction
  output fetch_pkg::inst_t inst_o,
  output fetch_pkg::addr_t pc_o,
  output logic             inst_valid_o,
  output logic             fetch_fault_o
);
  import fetch_pkg::*;

  // pc_gen to master
  addr_t pc;
  logic  pc_ok;

  // master to pc_gen and inst_align
  logic  done;
  addr_t done_pc;
  word_t done_data;
  logic  done_err;

  // master to memory
  axi_rd_if bus ();

  pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .done_i        (done),
    .pc_o          (pc),
    .pc_ok_o       (pc_ok)
  );

  // redirect doubles as flush of the read in flight
  axi_rd_master u_axi_rd_master (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc_i        (pc),
    .pc_ok_i     (pc_ok),
    .flush_i     (redirect_i),
    .bus         (bus.master),
    .done_o      (done),
    .done_pc_o   (done_pc),
    .done_data_o (done_data),
    .done_err_o  (done_err)
  );

  imem_axi_slave u_imem_axi_slave (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (bus.slave),
    .load_we_i   (load_we_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i)
  );

  inst_align u_inst_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .done_i        (done),
    .done_pc_i     (done_pc),
    .done_data_i   (done_data),
    .done_err_i    (done_err),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_valid_o  (inst_valid_o),
    .fetch_fault_o (fetch_fault_o)
  );

endmodule

`default_nettype wire

//--- test/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_tb;

  // one fetched instruction and the controls applied before it
  typedef struct packed {
    logic        redirect;
    logic [63:0] target;
    int          stall;
    logic [63:0] exp_pc;
    logic [31:0] exp_inst;
    logic        exp_fault;
  } step_t;

  logic        clk           = 1'b0;
  logic        rst_n         = 1'b0;
  logic        redirect_i    = 1'b0;
  logic [63:0] redirect_pc_i = '0;
  logic        stall_i       = 1'b0;
  logic        load_we_i     = 1'b0;
  logic [63:0] load_addr_i   = '0;
  logic [63:0] load_data_i   = '0;
  logic [31:0] inst_o;
  logic [63:0] pc_o;
  logic        inst_valid_o;
  logic        fetch_fault_o;

  logic [63:0] load_addr_q[$];
  logic [63:0] load_data_q[$];
  step_t       steps[$];
  bit          cases_read = 1'b0;
  int          seed       = 32'h7321_2e60;

  fetch_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .inst_valid_o  (inst_valid_o),
    .fetch_fault_o (fetch_fault_o)
  );

  // 4 ns period
  always #2 clk = ~clk;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    string line;
    if (actual !== expected) begin
      line = $sformatf("** Error at %0d ns: %s = %h, expected %h",
                       $time, name, actual, expected);
      stop_run(line);
    end
  endtask

  // L records preload memory and S records are fetch steps
  task automatic read_cases();
    int          fd;
    int          c;
    int          n;
    int          flag;
    int          stall;
    int          fault;
    logic [7:0]  ch;
    logic [63:0] a;
    logic [63:0] d;
    logic [31:0] inst;
    step_t       st;
    fd = $fopen("test/fetch_cases.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open test/fetch_cases.txt");
    end
    c = $fgetc(fd);
    while (c >= 0) begin
      ch = c[7:0];
      if (ch == "#") begin
        while (c >= 0 && c != 10) begin
          c = $fgetc(fd);
        end
      end else if (ch == "L") begin
        n = $fscanf(fd, "%h %h", a, d);
        if (n != 2) begin
          stop_run("malformed load record in case file");
        end
        load_addr_q.push_back(a);
        load_data_q.push_back(d);
      end else if (ch == "S") begin
        n = $fscanf(fd, "%d %h %d %h %h %d", flag, a, stall, d, inst, fault);
        if (n != 6) begin
          stop_run("malformed step record in case file");
        end
        st.redirect  = (flag != 0);
        st.target    = a;
        st.stall     = stall;
        st.exp_pc    = d;
        st.exp_inst  = inst;
        st.exp_fault = (fault != 0);
        steps.push_back(st);
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  // apply controls right after the previous pulse, then wait for the next one
  // a stall stays up for its length past that pulse
  task automatic run_step(input step_t st);
    int hold;
    int after;
    bit got;
    bit busy;
    hold = st.stall;
    if (hold < 0) begin
      // random stall of 1 to 8 cycles
      hold = 1 + int'($unsigned($random(seed)) % 32'd8);
    end
    @(posedge clk);
    redirect_i    <= st.redirect;
    redirect_pc_i <= st.target;
    stall_i       <= (hold > 0);
    after = 0;
    got   = 1'b0;
    busy  = 1'b1;
    while (busy) begin
      @(negedge clk);
      if (inst_valid_o) begin
        // only the fetch already in flight may retire under stall
        if (got) begin
          stop_run("a second instruction came out while the stall was held");
        end
        got = 1'b1;
        check_value("pc_o", pc_o, st.exp_pc);
        check_value("inst_o", 64'(inst_o), 64'(st.exp_inst));
        check_value("fetch_fault_o", 64'(fetch_fault_o), 64'(st.exp_fault));
      end else begin
        check_value("fetch_fault_o", 64'(fetch_fault_o), 64'd0);
      end
      if (got && after >= hold) begin
        busy = 1'b0;
      end else begin
        @(posedge clk);
        // redirect is a single cycle level
        redirect_i <= 1'b0;
        if (got) begin
          after++;
        end
        if (after >= hold) begin
          stall_i <= 1'b0;
        end
      end
    end
  endtask

  initial begin
    read_cases();
    cases_read = 1'b1;
    // preload while the core sits in reset
    foreach (load_addr_q[k]) begin
      @(posedge clk);
      load_we_i   <= 1'b1;
      load_addr_i <= load_addr_q[k];
      load_data_i <= load_data_q[k];
    end
    @(posedge clk);
    load_we_i <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("inst_valid_o", 64'(inst_valid_o), 64'd0);
    check_value("fetch_fault_o", 64'(fetch_fault_o), 64'd0);
    check_value("inst_o", 64'(inst_o), 64'(`NOP_INST));
    foreach (steps[k]) begin
      run_step(steps[k]);
    end
    if (steps.size() == 0) begin
      stop_run("the case file holds no fetch steps");
    end else begin
      $display("No errors");
      $finish;
    end
  end

  // watchdog of 40 cycles per step plus margin for preload and reset
  initial begin
    wait (cases_read);
    repeat (steps.size() * 40 + 200) @(posedge clk);
    stop_run("watchdog expired before all fetch steps completed");
  end

endmodule

`default_nettype wire

//--- test/fetch_cases.txt
# L <byte addr> <64-bit word>
# S <redirect> <target> <stall cycles, -1 random> <exp pc> <exp inst> <exp fault>
L 80000000 0020011300100093
L 80000008 0040021300300193
L 80000010 0060031300500293
L 80000018 0080041300700393
L 80000020 00a0051300900493
L 80000028 00c0061300b00593
L 80000100 0120091301100893
L 80000108 01400a1301300993
L 80000110 01600b1301500a93
L 800007f8 01800c1301700b93
S 0 0 0 80000000 00100093 0
S 0 0 0 80000004 00200113 0
S 0 0 0 80000008 00300193 0
S 0 0 0 8000000c 00400213 0
S 1 80000104 0 80000104 01200913 0
S 0 0 0 80000108 01300993 0
S 0 0 0 8000010c 01400a13 0
S 1 80000010 0 80000010 00500293 0
S 0 0 8 80000014 00600313 0
S 0 0 0 80000018 00700393 0
S 0 0 2 8000001c 00800413 0
S 0 0 0 80000020 00900493 0
S 0 0 -1 80000024 00a00513 0
S 0 0 -1 80000028 00b00593 0
S 0 0 0 8000002c 00c00613 0
S 1 80000800 0 80000800 00000013 1
S 0 0 0 80000804 00000013 1
S 1 1000 0 1000 00000013 1
S 1 800007fc 0 800007fc 01800c13 0
S 0 0 0 80000800 00000013 1
S 1 80000110 0 80000110 01500a93 0
S 0 0 0 80000114 01600b13 0

//--- sources.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/axi_rd_if.sv
hdl/pc_gen.sv
hdl/axi_rd_master.sv
hdl/imem_axi_slave.sv
hdl/inst_align.sv
hdl/fetch_top.sv
test/fetch_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f sources.f --top-module fetch_tb -o Vfetch_tb

out=$(./obj_dir/Vfetch_tb 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
